// File: all.f
+incdir+common
common/coreExePkg.sv
rtl/regFile.sv
exe/exeStage.sv
rtl/memStage.sv
rtl/exeCore.sv
bench/exeCoreTb.sv

// File: bench/exeCoreTb.sv
// Testbench with random program generator, reference model, event compare tasks and timeout
`default_nettype none

`include "coreExe_params.svh"

module exeCoreTb
  import coreExePkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumInst     = 400;
  localparam int InitInst    = `COREEXE_REGS - 1;    // x1 to x31 written first
  localparam int CycleLimit  = NumInst * 3 + 100;
  localparam int MemWords    = `COREEXE_DMEM_WORDS;
  localparam int AddrW       = $bits(t_dmemAddr);
  localparam int DrainCycles = 8;                    // Ready cycles to flush Q101H to Q105H

  logic      Clock;
  logic      rst;
  logic      ready;
  logic      instValid;
  t_word     pc;
  t_regIdx   rs1;
  t_regIdx   rs2;
  t_regIdx   rd;
  logic      regWrEn;
  t_word     imm;
  t_aluOp    aluOp;
  logic      mulEn;
  t_branchOp branchOp;
  logic      selAluPc;
  logic      selAluImm;
  logic      lui;
  logic      memRd;
  logic      memWr;
  logic      wbValid;
  t_regIdx   wbRd;
  t_word     wbData;
  logic      branchValid;
  logic      branchTaken;
  t_word     branchTarget;

  // Reference model state
  t_word     modelReg [`COREEXE_REGS];
  t_word     modelMem [MemWords];
  t_dmemAddr storedAddr [$];   // Words with defined contents
  t_regIdx   recentRd [$];     // Last few destinations, biases sources
  t_regIdx   loadRd;           // Nonzero right after a load
  t_word     pcNext;
  t_regIdx   expWbRd [$];
  t_word     expWbData [$];
  logic      expTaken [$];
  t_word     expTarget [$];
  int        cycles;
  int        issued;
  int        drained;          // Ready cycles seen after the last issue

  exeCore exeCore_inst (
    .Clock        (Clock),
    .rst          (rst),
    .ready        (ready),
    .instValid    (instValid),
    .pc           (pc),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .regWrEn      (regWrEn),
    .imm          (imm),
    .aluOp        (aluOp),
    .mulEn        (mulEn),
    .branchOp     (branchOp),
    .selAluPc     (selAluPc),
    .selAluImm    (selAluImm),
    .lui          (lui),
    .memRd        (memRd),
    .memWr        (memWr),
    .wbValid      (wbValid),
    .wbRd         (wbRd),
    .wbData       (wbData),
    .branchValid  (branchValid),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

  initial Clock = 1'b0;
  always #20 Clock = ~Clock;    // 40 ns period

  // ==========================================================================
  // Failure reporting and compare tasks
  // ==========================================================================
  task automatic failRun(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic checkWb(input t_regIdx gotRd, input t_word gotData);
    t_regIdx wantRd;
    t_word   wantData;
    if (expWbRd.size() == 0) begin
      failRun($sformatf("Unexpected write-back to x%0d at %0t ns", gotRd, $time));
    end
    wantRd   = expWbRd.pop_front();
    wantData = expWbData.pop_front();
    if (gotRd !== wantRd) begin
      failRun($sformatf("** Error at %0t ns: wbRd expected %0d got %0d",
                        $time, wantRd, gotRd));
    end
    if (gotData !== wantData) begin
      failRun($sformatf("** Error at %0t ns: wbData expected %h got %h",
                        $time, wantData, gotData));
    end
  endtask

  task automatic checkBranch(input logic gotTaken, input t_word gotTarget);
    logic  wantTaken;
    t_word wantTarget;
    if (expTaken.size() == 0) begin
      failRun($sformatf("Unexpected branch outcome at %0t ns", $time));
    end
    wantTaken  = expTaken.pop_front();
    wantTarget = expTarget.pop_front();
    if (gotTaken !== wantTaken) begin
      failRun($sformatf("** Error at %0t ns: branchTaken expected %b got %b",
                        $time, wantTaken, gotTaken));
    end
    if (gotTarget !== wantTarget) begin
      failRun($sformatf("** Error at %0t ns: branchTarget expected %h got %h",
                        $time, wantTarget, gotTarget));
    end
  endtask

  // ==========================================================================
  // Reference model from the RV32I definitions
  // ==========================================================================
  function automatic t_word aluRef(t_aluOp op, t_word a, t_word b);
    logic [4:0] sh;
    t_word      r;
    sh = b[4:0];
    case (op)
      ADD:     r = a + b;
      SUB:     r = a + ~b + 1;
      SLT:     r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};  // Sign bits differ
      SLTU:    r = {31'b0, a < b};
      SLL:     r = a << sh;
      SRL:     r = a >> sh;
      SRA:     r = (a >> sh) | (a[31] ? ~({32{1'b1}} >> sh) : 32'b0);   // Sign fill
      XOR:     r = a ^ b;
      OR:      r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branchRef(t_branchOp op, t_word a, t_word b);
    logic lessU;
    logic lessS;
    logic r;
    lessU = (a < b);
    lessS = (a[31] != b[31]) ? a[31] : lessU;
    case (op)
      BEQ:     r = (a == b);
      BNE:     r = (a != b);
      BLT:     r = lessS;
      BGE:     r = !lessS;
      BLTU:    r = lessU;
      default: r = !lessU;   // BGEU
    endcase
    return r;
  endfunction

  // Runs the instruction now on the DUT inputs, in program order
  task automatic modelExec();
    t_word     a;
    t_word     b;
    t_word     res;
    t_dmemAddr w;
    a = selAluPc ? pc : modelReg[rs1];
    b = selAluImm ? imm : modelReg[rs2];
    if (lui) begin
      res = imm;
    end else if (mulEn) begin
      res = a * b;             // Low word only
    end else begin
      res = aluRef(aluOp, a, b);
    end
    w = res[AddrW+1:2];
    if (branchOp != BNONE) begin
      expTaken.push_back(branchRef(branchOp, modelReg[rs1], modelReg[rs2]));
      expTarget.push_back(pc + imm);
    end
    if (memWr) modelMem[w] = modelReg[rs2];
    if (memRd) res = modelMem[w];
    if (regWrEn) begin
      expWbRd.push_back(rd);
      expWbData.push_back(res);
      if (rd != '0) modelReg[rd] = res;   // x0 stays zero
    end
  endtask

  // ==========================================================================
  // Program generator
  // ==========================================================================
  // Half the time a recent destination, never the rd of a load just issued
  function automatic t_regIdx pickSrc();
    t_regIdx r;
    do begin
      if ((recentRd.size() > 0) && ($urandom_range(0, 1) == 1)) begin
        r = recentRd[$urandom_range(0, recentRd.size() - 1)];
      end else begin
        r = t_regIdx'($urandom_range(0, 31));
      end
    end while ((loadRd != '0) && (r == loadRd));
    return r;
  endfunction

  task automatic genInst(input int idx);
    int          kind;
    t_dmemAddr   w;
    logic [31:0] r;
    r         = $urandom;
    instValid = 1'b1;
    pc        = pcNext;
    pcNext    = pcNext + 4;
    rs1       = '0;
    rs2       = '0;
    rd        = ($urandom_range(0, 19) == 0) ? '0 : t_regIdx'($urandom_range(1, 31));
    regWrEn   = 1'b1;
    imm       = {{20{r[11]}}, r[11:0]};   // I-type immediate
    aluOp     = ADD;
    mulEn     = 1'b0;
    branchOp  = BNONE;
    selAluPc  = 1'b0;
    selAluImm = 1'b0;
    lui       = 1'b0;
    memRd     = 1'b0;
    memWr     = 1'b0;
    if (idx < InitInst) begin
      rd        = t_regIdx'(idx + 1);     // Defines every register
      imm       = $urandom;
      selAluImm = 1'b1;
    end else begin
      kind = $urandom_range(0, 9);
      rs1  = pickSrc();
      rs2  = pickSrc();
      if ((kind == 8) && (storedAddr.size() == 0)) kind = 7;  // Nothing to load yet
      case (kind)
        0, 1, 2: aluOp = t_aluOp'($urandom_range(0, 9));
        3, 4: begin
          aluOp     = t_aluOp'($urandom_range(0, 9));
          selAluImm = 1'b1;
        end
        5: begin                               // LUI or AUIPC
          imm       = {r[31:12], 12'b0};
          selAluImm = 1'b1;
          lui       = r[0];
          selAluPc  = !r[0];
        end
        6: mulEn = 1'b1;
        7: begin                               // SW
          w         = t_dmemAddr'($urandom_range(0, MemWords - 1));
          imm       = {w, 2'b00} - modelReg[rs1];
          selAluImm = 1'b1;
          memWr     = 1'b1;
          regWrEn   = 1'b0;
          storedAddr.push_back(w);
        end
        8: begin                               // LW
          w         = storedAddr[$urandom_range(0, storedAddr.size() - 1)];
          imm       = {w, 2'b00} - modelReg[rs1];
          selAluImm = 1'b1;
          memRd     = 1'b1;
        end
        default: begin
          branchOp = t_branchOp'($urandom_range(1, 6));
          imm      = {{19{r[12]}}, r[12:1], 1'b0};  // B-type offset
          regWrEn  = 1'b0;
        end
      endcase
    end
    loadRd = memRd ? rd : '0;
    if (regWrEn) begin
      recentRd.push_back(rd);
      if (recentRd.size() > 4) void'(recentRd.pop_front());
    end
  endtask

  // ==========================================================================
  // Output monitor and timeout
  // ==========================================================================
  // Outputs hold while stalled, so only a ready cycle counts
  always @(negedge Clock) begin
    if (!rst && ready) begin
      if (wbValid) checkWb(wbRd, wbData);
      if (branchValid) checkBranch(branchTaken, branchTarget);
    end
  end

  always @(posedge Clock) begin
    cycles = cycles + 1;
    if (cycles >= CycleLimit) begin
      failRun($sformatf("Timeout after %0d cycles, pipeline events still missing", cycles));
    end
  end

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    void'($urandom(38101));
    rst         = 1'b1;
    ready       = 1'b0;
    instValid   = 1'b0;
    pc          = '0;
    rs1         = '0;
    rs2         = '0;
    rd          = '0;
    regWrEn     = 1'b0;
    imm         = '0;
    aluOp       = ADD;
    mulEn       = 1'b0;
    branchOp    = BNONE;
    selAluPc    = 1'b0;
    selAluImm   = 1'b0;
    lui         = 1'b0;
    memRd       = 1'b0;
    memWr       = 1'b0;
    modelReg[0] = '0;
    loadRd      = '0;
    pcNext      = 32'h0000_1000;
    cycles      = 0;
    issued      = 0;
    drained     = 0;
    repeat (4) @(posedge Clock);
    #2;
    rst = 1'b0;

    // About 20% stall cycles and 10% bubbles
    while (issued < NumInst) begin
      ready = ($urandom_range(0, 4) != 0);
      if (ready && ($urandom_range(0, 9) == 0)) begin
        instValid = 1'b0;
      end else if (ready) begin
        genInst(issued);
        modelExec();
        issued++;
      end
      @(posedge Clock);
      #2;
    end

    // Drain with stalls until the last instruction is past Q105H
    instValid = 1'b0;
    while (drained < DrainCycles) begin
      ready = ($urandom_range(0, 4) != 0);
      if (ready) drained++;
      @(posedge Clock);
      #2;
    end

    if ((expWbRd.size() != 0) || (expTaken.size() != 0)) begin
      failRun("Expected events left over at end of run");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: rtl/exeCore.sv
// Execute pipeline top with the Q101H to Q105H control pipeline and stage wiring
`default_nettype none

`include "coreExe_params.svh"

module exeCore
  import coreExePkg::*;
(
  input  var logic      Clock,
  input  var logic      rst,
  input  var logic      ready,        // Low freezes every stage
  // Decoded instruction at Q101H
  input  var logic      instValid,
  input  var t_word     pc,
  input  var t_regIdx   rs1,
  input  var t_regIdx   rs2,
  input  var t_regIdx   rd,
  input  var logic      regWrEn,
  input  var t_word     imm,
  input  var t_aluOp    aluOp,
  input  var logic      mulEn,
  input  var t_branchOp branchOp,
  input  var logic      selAluPc,
  input  var logic      selAluImm,
  input  var logic      lui,
  input  var logic      memRd,
  input  var logic      memWr,
  // Retired register write
  output logic          wbValid,
  output t_regIdx       wbRd,
  output t_word         wbData,
  // Branch outcome
  output logic          branchValid,
  output logic          branchTaken,
  output t_word         branchTarget
);

  logic      validQ102;
  t_word     pcQ102;
  t_word     immQ102;
  t_regIdx   rs1Q102;
  t_regIdx   rs2Q102;
  t_regIdx   rdQ102;
  logic      regWrEnQ102;
  t_aluOp    aluOpQ102;
  logic      mulEnQ102;
  t_branchOp branchOpQ102;
  logic      selAluPcQ102;
  logic      selAluImmQ102;
  logic      luiQ102;
  logic      memRdQ102;
  logic      memWrQ102;
  t_word     rdData1;          // Q101H register file read
  t_word     rdData2;
  t_word     preRdData1;
  t_word     preRdData2;
  logic      takenQ102;        // Unqualified condition
  logic      validQ103;
  logic      validQ104;
  logic      validQ105;
  t_regIdx   rdQ103;
  t_regIdx   rdQ104;
  t_regIdx   rdQ105;
  logic      regWrEnQ103;
  logic      regWrEnQ104;
  logic      regWrEnQ105;
  logic      memRdQ103;
  logic      memWrQ103;
  t_word     aluOutQ103;
  t_word     dMemWrDataQ103;
  t_word     aluOutQ104;
  t_word     regWrDataQ105;

  // =========================================================================
  // Q101H register read and Q102H capture
  // =========================================================================
  regFile #(.NumRegs(`COREEXE_REGS)) regFile_inst (
    .Clock   (Clock),
    .rdIdx1  (rs1),
    .rdIdx2  (rs2),
    .rdData1 (rdData1),
    .rdData2 (rdData2),
    .wrEn    (wbValid && ready),   // One write per retired instruction
    .wrIdx   (rdQ105),
    .wrData  (regWrDataQ105)
  );

  // Control fields load only on a real instruction
  always_ff @(posedge Clock) begin
    if (rst) begin
      validQ102     <= 1'b0;
      rs1Q102       <= '0;
      rs2Q102       <= '0;
      rdQ102        <= '0;
      regWrEnQ102   <= 1'b0;
      aluOpQ102     <= ADD;
      mulEnQ102     <= 1'b0;
      branchOpQ102  <= BNONE;
      selAluPcQ102  <= 1'b0;
      selAluImmQ102 <= 1'b0;
      luiQ102       <= 1'b0;
      memRdQ102     <= 1'b0;
      memWrQ102     <= 1'b0;
    end else if (ready) begin
      validQ102 <= instValid;
      if (instValid) begin
        rs1Q102       <= rs1;
        rs2Q102       <= rs2;
        rdQ102        <= rd;
        regWrEnQ102   <= regWrEn;
        aluOpQ102     <= aluOp;
        mulEnQ102     <= mulEn;
        branchOpQ102  <= branchOp;
        selAluPcQ102  <= selAluPc;
        selAluImmQ102 <= selAluImm;
        luiQ102       <= lui;
        memRdQ102     <= memRd;
        memWrQ102     <= memWr;
      end
    end
  end

  // Payload
  always_ff @(posedge Clock) begin
    if (ready) begin
      pcQ102     <= pc;
      immQ102    <= imm;
      preRdData1 <= rdData1;
      preRdData2 <= rdData2;
    end
  end

  // =========================================================================
  // Q103H to Q105H control pipeline
  // =========================================================================
  always_ff @(posedge Clock) begin
    if (rst) begin
      validQ103 <= 1'b0;
      validQ104 <= 1'b0;
      validQ105 <= 1'b0;
    end else if (ready) begin
      validQ103 <= validQ102;
      validQ104 <= validQ103;
      validQ105 <= validQ104;
    end
  end

  always_ff @(posedge Clock) begin
    if (ready) begin
      rdQ103      <= rdQ102;
      regWrEnQ103 <= regWrEnQ102;
      memRdQ103   <= memRdQ102;
      memWrQ103   <= memWrQ102;
      rdQ104      <= rdQ103;
      regWrEnQ104 <= regWrEnQ103;
      rdQ105      <= rdQ104;
      regWrEnQ105 <= regWrEnQ104;
    end
  end

  // =========================================================================
  // Stages
  // =========================================================================
  exeStage exeStage_inst (
    .Clock          (Clock),
    .ready          (ready),
    .rs1            (rs1Q102),
    .rs2            (rs2Q102),
    .aluOp          (aluOpQ102),
    .branchOp       (branchOpQ102),
    .mulEn          (mulEnQ102),
    .selAluPc       (selAluPcQ102),
    .selAluImm      (selAluImmQ102),
    .lui            (luiQ102),
    .pc             (pcQ102),
    .imm            (immQ102),
    .preRdData1     (preRdData1),
    .preRdData2     (preRdData2),
    .rdQ103         (rdQ103),
    .wrEnQ103       (validQ103 && regWrEnQ103),
    .rdQ104         (rdQ104),
    .wrEnQ104       (validQ104 && regWrEnQ104),
    .rdQ105         (rdQ105),
    .wrEnQ105       (wbValid),
    .aluOutQ104     (aluOutQ104),
    .regWrDataQ105  (regWrDataQ105),
    .branchTaken    (takenQ102),
    .branchTarget   (branchTarget),
    .aluOutQ103     (aluOutQ103),
    .dMemWrDataQ103 (dMemWrDataQ103)
  );

  memStage memStage_inst (
    .Clock          (Clock),
    .rst            (rst),
    .ready          (ready),
    .memRdQ103      (validQ103 && memRdQ103),
    .memWrQ103      (validQ103 && memWrQ103),
    .aluOutQ103     (aluOutQ103),
    .dMemWrDataQ103 (dMemWrDataQ103),
    .aluOutQ104     (aluOutQ104),
    .regWrDataQ105  (regWrDataQ105)
  );

  // Outputs
  assign branchValid = validQ102 && (branchOpQ102 != BNONE);
  assign branchTaken = branchValid && takenQ102;
  assign wbValid     = validQ105 && regWrEnQ105;  // Also the Q105H write enable
  assign wbRd        = rdQ105;
  assign wbData      = regWrDataQ105;

endmodule

`default_nettype wire

// File: rtl/memStage.sv
// Data memory with Q103H access, Q104H load register and Q105H write-back register
`default_nettype none

`include "coreExe_params.svh"

module memStage
  import coreExePkg::*;
(
  input  var logic  Clock,
  input  var logic  rst,
  input  var logic  ready,
  // Q103H access
  input  var logic  memRdQ103,       // Valid qualified LW
  input  var logic  memWrQ103,       // Valid qualified SW
  input  var t_word aluOutQ103,      // Byte address
  input  var t_word dMemWrDataQ103,
  // Results
  output t_word     aluOutQ104,      // Q104H forwarding value
  output t_word     regWrDataQ105
);

  localparam int AddrW = $bits(t_dmemAddr);

  t_word     dMem [`COREEXE_DMEM_WORDS];
  t_dmemAddr wordAddr;
  t_word     loadDataQ104;
  t_word     aluOutRegQ104;
  logic      loadQ104;

  // =========================================================================
  // Q103H memory access
  // =========================================================================
  assign wordAddr = aluOutQ103[AddrW+1:2];   // Word index

  // Store commits on the edge closing Q103H
  always_ff @(posedge Clock) begin
    if (ready && memWrQ103) begin
      dMem[wordAddr] <= dMemWrDataQ103;
    end
  end

  // Synchronous read
  always_ff @(posedge Clock) begin
    if (ready) begin
      loadDataQ104  <= dMem[wordAddr];
      aluOutRegQ104 <= aluOutQ103;
    end
  end

  // Load flag follows the instruction into Q104H
  always_ff @(posedge Clock) begin
    if (rst) begin
      loadQ104 <= 1'b0;
    end else if (ready) begin
      loadQ104 <= memRdQ103;
    end
  end

  // =========================================================================
  // Q104H result select
  // =========================================================================
  // Load data replaces the address so a distance 2 consumer sees the word
  assign aluOutQ104 = loadQ104 ? loadDataQ104 : aluOutRegQ104;

  // Q104H to Q105H
  always_ff @(posedge Clock) begin
    if (ready) begin
      regWrDataQ105 <= aluOutQ104;
    end
  end

  // Program addresses must stay inside the memory
  addrInRange: assert property (@(posedge Clock) disable iff (rst)
    (memRdQ103 || memWrQ103) |-> (aluOutQ103[`COREEXE_XLEN-1:AddrW+2] == '0));

endmodule

`default_nettype wire

// File: exe/exeStage.sv
// Q102H execute with hazard detection, forwarding, ALU, MUL, branch compare, Q103H flops
`default_nettype none

`include "coreExe_params.svh"

module exeStage
  import coreExePkg::*;
(
  input  var logic      Clock,
  input  var logic      ready,         // Pipeline advance
  // Q102H instruction fields
  input  var t_regIdx   rs1,
  input  var t_regIdx   rs2,
  input  var t_aluOp    aluOp,
  input  var t_branchOp branchOp,
  input  var logic      mulEn,         // Low product instead of ALU
  input  var logic      selAluPc,
  input  var logic      selAluImm,
  input  var logic      lui,
  input  var t_word     pc,
  input  var t_word     imm,
  input  var t_word     preRdData1,    // Register file values before forwarding
  input  var t_word     preRdData2,
  // Destinations still in flight
  input  var t_regIdx   rdQ103,
  input  var logic      wrEnQ103,      // Already valid qualified
  input  var t_regIdx   rdQ104,
  input  var logic      wrEnQ104,
  input  var t_regIdx   rdQ105,
  input  var logic      wrEnQ105,
  // Forwarding sources from memStage
  input  var t_word     aluOutQ104,
  input  var t_word     regWrDataQ105,
  // Results
  output logic          branchTaken,
  output t_word         branchTarget,
  output t_word         aluOutQ103,
  output t_word         dMemWrDataQ103
);

  localparam int ShamtW = $clog2(`COREEXE_XLEN);

  logic              hit1Q103;
  logic              hit1Q104;
  logic              hit1Q105;
  logic              hit2Q103;
  logic              hit2Q104;
  logic              hit2Q105;
  t_word             fwdData1;     // rs1 after forwarding
  t_word             fwdData2;     // rs2 after forwarding
  t_word             aluIn1;
  t_word             aluIn2;
  logic [ShamtW-1:0] shamt;
  t_word             preAluOut;
  t_word             mulOut;
  t_word             aluOut;

  // Source matches a live destination, x0 excluded
  function automatic logic srcHit(t_regIdx src, t_regIdx dst, logic wrEn);
    return wrEn && (src == dst) && (src != '0);
  endfunction

  // =========================================================================
  // Hazard detection and forwarding
  // =========================================================================
  assign hit1Q103 = srcHit(rs1, rdQ103, wrEnQ103);
  assign hit1Q104 = srcHit(rs1, rdQ104, wrEnQ104);
  assign hit1Q105 = srcHit(rs1, rdQ105, wrEnQ105);
  assign hit2Q103 = srcHit(rs2, rdQ103, wrEnQ103);
  assign hit2Q104 = srcHit(rs2, rdQ104, wrEnQ104);
  assign hit2Q105 = srcHit(rs2, rdQ105, wrEnQ105);

  // Nearest producer wins
  assign fwdData1 = hit1Q103 ? aluOutQ103    :  // Distance 1
                    hit1Q104 ? aluOutQ104    :  // Distance 2
                    hit1Q105 ? regWrDataQ105 :  // Distance 3
                               preRdData1;      // No hazard

  assign fwdData2 = hit2Q103 ? aluOutQ103    :
                    hit2Q104 ? aluOutQ104    :
                    hit2Q105 ? regWrDataQ105 :
                               preRdData2;

  // Operand select for AUIPC style and immediate forms
  assign aluIn1 = selAluPc  ? pc  : fwdData1;
  assign aluIn2 = selAluImm ? imm : fwdData2;

  // =========================================================================
  // ALU and multiplier
  // =========================================================================
  assign shamt = aluIn2[ShamtW-1:0];

  always_comb begin
    case (aluOp)
      ADD:     preAluOut = aluIn1 + aluIn2;
      SUB:     preAluOut = aluIn1 - aluIn2;
      SLT:     preAluOut = t_word'($signed(aluIn1) < $signed(aluIn2));
      SLTU:    preAluOut = t_word'(aluIn1 < aluIn2);
      SLL:     preAluOut = aluIn1 << shamt;
      SRL:     preAluOut = aluIn1 >> shamt;
      SRA:     preAluOut = $signed(aluIn1) >>> shamt;
      XOR:     preAluOut = aluIn1 ^ aluIn2;
      OR:      preAluOut = aluIn1 | aluIn2;
      AND:     preAluOut = aluIn1 & aluIn2;
      default: preAluOut = aluIn1 + aluIn2;
    endcase
    if (lui) begin
      preAluOut = imm;                           // Upper immediate as is
    end
  end

  assign mulOut = aluIn1 * aluIn2;               // Low 32 bits only
  assign aluOut = mulEn ? mulOut : preAluOut;

  // =========================================================================
  // Branch condition and target
  // =========================================================================
  always_comb begin
    case (branchOp)
      BEQ:     branchTaken = (fwdData1 == fwdData2);
      BNE:     branchTaken = (fwdData1 != fwdData2);
      BLT:     branchTaken = ($signed(fwdData1) < $signed(fwdData2));
      BGE:     branchTaken = !($signed(fwdData1) < $signed(fwdData2));
      BLTU:    branchTaken = (fwdData1 < fwdData2);
      BGEU:    branchTaken = !(fwdData1 < fwdData2);
      default: branchTaken = 1'b0;               // BNONE
    endcase
  end

  assign branchTarget = pc + imm;

  // Q102H to Q103H
  always_ff @(posedge Clock) begin
    if (ready) begin
      aluOutQ103     <= aluOut;
      dMemWrDataQ103 <= fwdData2;                // Store data after forwarding
    end
  end

  // exeCore resets the Q102H op to ADD, so after any advance it must be defined
  aluOpKnown: assert property (@(posedge Clock) ready |=> !$isunknown(aluOp));

endmodule

`default_nettype wire

// File: rtl/regFile.sv
// Register file with two combinational read ports, one write port and write bypass
`default_nettype none

module regFile
  import coreExePkg::*;
#(
  parameter int NumRegs = 2 ** $bits(t_regIdx) // Matches register index width
) (
  input  var logic    Clock,
  // Read ports used at Q101H
  input  var t_regIdx rdIdx1,
  input  var t_regIdx rdIdx2,
  output t_word       rdData1,
  output t_word       rdData2,
  // Write port driven from Q105H
  input  var logic    wrEn,
  input  var t_regIdx wrIdx,
  input  var t_word   wrData
);

  t_word regArr [NumRegs]; // Entry 0 never written

  // Zero for x0, then same-cycle write, then stored value
  function automatic t_word readPort(t_regIdx idx, t_word stored, logic we,
                                     t_regIdx wIdx, t_word wData);
    t_word result;
    if (idx == '0) begin
      result = '0;              // x0 hardwired
    end else if (we && (wIdx == idx)) begin
      result = wData;           // Write-through bypass
    end else begin
      result = stored;
    end
    return result;
  endfunction

  // Write lands on the edge closing Q105H
  always_ff @(posedge Clock) begin
    if (wrEn && (wrIdx != '0)) begin
      regArr[wrIdx] <= wrData;
    end
  end

  assign rdData1 = readPort(rdIdx1, regArr[rdIdx1], wrEn, wrIdx, wrData);
  assign rdData2 = readPort(rdIdx2, regArr[rdIdx2], wrEn, wrIdx, wrData);

  // x0 must read zero even while a write to x0 retires on the bypass path
  x0ReadZero1: assert property (@(posedge Clock) (rdIdx1 == '0) |-> (rdData1 == '0));
  x0ReadZero2: assert property (@(posedge Clock) (rdIdx2 == '0) |-> (rdData2 == '0));

endmodule

`default_nettype wire

// File: common/coreExePkg.sv
// Datapath typedefs plus ALU and branch opcode enums for the execute pipeline
`default_nettype none

`include "coreExe_params.svh"

package coreExePkg;

  // =========================================================================
  // Datapath types
  // =========================================================================
  typedef logic [`COREEXE_XLEN-1:0]               t_word;     // Data, immediate, PC
  typedef logic [$clog2(`COREEXE_REGS)-1:0]       t_regIdx;   // Register number
  typedef logic [$clog2(`COREEXE_DMEM_WORDS)-1:0] t_dmemAddr; // Data memory word index

  // =========================================================================
  // Opcodes
  // =========================================================================
  // ALU function at Q102H
  typedef enum logic [3:0] {
    ADD  = 4'h0, // Also address calc for LW and SW
    SUB  = 4'h1,
    SLT  = 4'h2, // Signed compare
    SLTU = 4'h3, // Unsigned compare
    SLL  = 4'h4,
    SRL  = 4'h5,
    SRA  = 4'h6, // Arithmetic shift keeps sign
    XOR  = 4'h7,
    OR   = 4'h8,
    AND  = 4'h9
  } t_aluOp;

  // Branch condition
  // BNONE marks a non-branch instruction
  typedef enum logic [2:0] {
    BNONE = 3'h0,
    BEQ   = 3'h1,
    BNE   = 3'h2,
    BLT   = 3'h3, // Signed
    BGE   = 3'h4, // Signed
    BLTU  = 3'h5,
    BGEU  = 3'h6
  } t_branchOp;

endpackage

`default_nettype wire

// File: common/coreExe_params.svh
// Width and depth macros shared by the execute pipeline
`ifndef COREEXE_PARAMS_SVH
`define COREEXE_PARAMS_SVH

// =========================================================================
// Datapath
// =========================================================================
// RV32 integer word
`define COREEXE_XLEN 32

// Architectural registers x0 to x31
`define COREEXE_REGS 32

// =========================================================================
// Data memory
// =========================================================================
// Word addressed
// Index comes from address bits 9:2
`define COREEXE_DMEM_WORDS 256

`endif
